/* src/isa_pkg.sv */
package isa_pkg;

	// major opcode in the top five bits, implemented subset only
	typedef enum logic [4:0] {
		op_ld   = 5'd0,
		op_ldi  = 5'd1,
		op_st   = 5'd2,
		op_addi = 5'd12,
		op_andi = 5'd13,
		op_ori  = 5'd14,
		op_br   = 5'd19,
		op_jr   = 5'd20,
		op_jal  = 5'd21,
		op_in   = 5'd22,
		op_out  = 5'd23,
		op_nop  = 5'd26,
		op_halt = 5'd27
	} opcode_t;

	// condition code, carried in the low two bits of the rb field
	typedef enum logic [1:0] {
		br_zero     = 2'd0,
		br_nonzero  = 2'd1,
		br_positive = 2'd2,
		br_negative = 2'd3
	} br_cond_t;

	typedef enum logic [1:0] {
		alu_add    = 2'd0,
		alu_and    = 2'd1,
		alu_or     = 2'd2,
		alu_pass_b = 2'd3
	} alu_op_t;

	// memory, immediate, jump and i/o instructions
	typedef struct packed {
		opcode_t     op;
		logic [3:0]  ra;
		logic [3:0]  rb;
		logic [18:0] c;
	} imm_fmt_t;

	// conditional branch, rb field split into pad and condition
	typedef struct packed {
		opcode_t     op;
		logic [3:0]  ra;
		logic [1:0]  pad;
		br_cond_t    cond;
		logic [18:0] c;
	} br_fmt_t;

	typedef union packed {
		imm_fmt_t imm;
		br_fmt_t  br;
	} instr_t;

endpackage

/* src/mem_pkg.sv */
package mem_pkg;

	// one memory and register word
	typedef logic [31:0] word_t;

	// direction of a bus transaction
	typedef enum logic {
		mem_read  = 1'b0,
		mem_write = 1'b1
	} mem_op_t;

endpackage

/* src/ram.sv */
`timescale 1ns/10ps

module ram #(
	parameter int ADDR_W = 9
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 mem_req,
	input  mem_pkg::mem_op_t     mem_op,
	input  logic [ADDR_W-1:0]    mem_addr,
	input  mem_pkg::word_t       mem_wdata,
	output logic                 mem_ack,
	output mem_pkg::word_t       mem_rdata
);
	import mem_pkg::*;

	// 2^ADDR_W words, contents loaded over the host port
	word_t mem [2**ADDR_W];

	logic start;
	logic done;

	// new request seen while idle
	assign start = mem_req && !mem_ack;
	// master has released the request
	assign done = !mem_req && mem_ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_ack <= 1'b0;
			mem_rdata <= '0;
		end else if (start) begin
			mem_ack <= 1'b1;
			// read data only on a read, zero on a write
			mem_rdata <= (mem_op == mem_read) ? mem[mem_addr] : '0;
		end else if (done) begin
			mem_ack <= 1'b0;
			mem_rdata <= '0;
		end
	end

	// write lands on the same edge that raises ack
	always_ff @(posedge clk) begin
		if (rst_n && start && mem_op == mem_write)
			mem[mem_addr] <= mem_wdata;
	end

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [3:0]        ra_addr,
	input  logic [3:0]        rb_addr,
	input  logic              we,
	input  logic [3:0]        wr_addr,
	input  mem_pkg::word_t    wr_data,
	output mem_pkg::word_t    ra_data,
	output mem_pkg::word_t    rb_data
);
	import mem_pkg::*;

	// r0 is an ordinary register here
	word_t regs [16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// asynchronous read ports
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

/* src/alu.sv */
`timescale 1ns/10ps

module alu (
	input  isa_pkg::alu_op_t     op,
	input  mem_pkg::word_t       a,
	input  mem_pkg::word_t       b,
	input  isa_pkg::br_cond_t    cond,
	input  mem_pkg::word_t       test,
	output mem_pkg::word_t       result,
	output logic                 taken
);
	import isa_pkg::*;

	always_comb begin
		case (op)
			alu_add:
				result = a + b;
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;
			// used for jumps and i/o moves
			default:
				result = b;
		endcase
	end

	// branch decision on the ra register value
	always_comb begin
		case (cond)
			br_zero:
				taken = (test == '0);
			br_nonzero:
				taken = (test != '0);
			// strictly positive, zero does not count
			br_positive:
				taken = !test[31] && (test != '0);
			default:
				taken = test[31];
		endcase
	end

endmodule

/* src/control_unit.sv */
`timescale 1ns/10ps

module control_unit #(
	parameter int ADDR_W   = 9,
	parameter int RESET_PC = 0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  mem_pkg::word_t       in_data,
	input  logic                 mem_ack,
	input  mem_pkg::word_t       mem_rdata,
	input  mem_pkg::word_t       ra_data,
	input  mem_pkg::word_t       rb_data,
	input  mem_pkg::word_t       result,
	input  logic                 taken,
	input  logic                 host_req,
	input  mem_pkg::mem_op_t     host_op,
	input  logic [ADDR_W-1:0]    host_addr,
	input  mem_pkg::word_t       host_wdata,
	output logic                 mem_req,
	output mem_pkg::mem_op_t     mem_op,
	output logic [ADDR_W-1:0]    mem_addr,
	output mem_pkg::word_t       mem_wdata,
	output logic [3:0]           ra_addr,
	output logic [3:0]           rb_addr,
	output logic                 we,
	output logic [3:0]           wr_addr,
	output mem_pkg::word_t       wr_data,
	output isa_pkg::alu_op_t     alu_op,
	output mem_pkg::word_t       alu_a,
	output mem_pkg::word_t       alu_b,
	output isa_pkg::br_cond_t    cond,
	output mem_pkg::word_t       test,
	output logic                 host_ack,
	output mem_pkg::word_t       host_rdata,
	output logic                 halted,
	output mem_pkg::word_t       out_data,
	output logic                 out_strobe
);
	import isa_pkg::*;
	import mem_pkg::*;

	typedef enum logic [3:0] {
		s_idle,
		s_start,
		s_fetch_req,
		s_fetch_wait,
		s_fetch_rel,
		s_exec,
		s_data_req,
		s_data_wait,
		s_data_rel,
		s_wb,
		s_halt
	} state_t;

	state_t            state;
	logic [ADDR_W-1:0] pc;
	instr_t            ir;
	// alu result captured in execute, address or value
	word_t             res_q;
	logic              taken_q;
	// load data captured from the bus
	word_t             md_q;

	opcode_t           op;
	word_t             c_ext;
	word_t             base;
	logic [ADDR_W-1:0] pc_inc;
	logic              host_own;

	assign op = ir.imm.op;
	// 19-bit constant, sign extended
	assign c_ext = {{13{ir.imm.c[18]}}, ir.imm.c};
	// rb field of 0 selects a zero base, not r0
	assign base = (ir.imm.rb == 4'd0) ? '0 : rb_data;
	assign pc_inc = pc + 1'b1;
	// host owns the bus whenever no program is running
	assign host_own = (state == s_idle) || (state == s_halt);

	assign ra_addr = ir.imm.ra;
	assign rb_addr = ir.imm.rb;
	// branch view of the same word
	assign cond = ir.br.cond;
	assign test = ra_data;
	assign halted = (state == s_halt);

	// bus master, host pass-through when idle or halted
	always_comb begin
		mem_req = 1'b0;
		mem_op = mem_read;
		mem_addr = pc;
		mem_wdata = '0;
		host_ack = 1'b0;
		host_rdata = '0;
		if (host_own) begin
			mem_req = host_req;
			mem_op = host_op;
			mem_addr = host_addr;
			mem_wdata = host_wdata;
			host_ack = mem_ack;
			host_rdata = mem_rdata;
		end else if (state == s_fetch_req || state == s_fetch_wait) begin
			mem_req = 1'b1;
		end else if (state == s_data_req || state == s_data_wait) begin
			mem_req = 1'b1;
			mem_op = (op == op_st) ? mem_write : mem_read;
			mem_addr = res_q[ADDR_W-1:0];
			mem_wdata = ra_data;
		end
	end

	// operand select per opcode
	always_comb begin
		alu_op = alu_add;
		alu_a = c_ext;
		alu_b = c_ext;
		case (op)
			op_ld, op_ldi, op_st:
				alu_b = base;
			op_addi:
				alu_a = rb_data;
			op_andi: begin
				alu_op = alu_and;
				alu_a = rb_data;
			end
			op_ori: begin
				alu_op = alu_or;
				alu_a = rb_data;
			end
			// branch target pc+1+c
			op_br:
				alu_a = {{(32-ADDR_W){1'b0}}, pc_inc};
			op_jr, op_jal, op_out: begin
				alu_op = alu_pass_b;
				alu_b = ra_data;
			end
			// input port sampled here in execute
			op_in: begin
				alu_op = alu_pass_b;
				alu_b = in_data;
			end
			default:
				alu_op = alu_add;
		endcase
	end

	// register writeback
	always_comb begin
		we = 1'b0;
		wr_addr = ir.imm.ra;
		wr_data = res_q;
		if (state == s_wb) begin
			case (op)
				op_ldi, op_addi, op_andi, op_ori, op_in:
					we = 1'b1;
				op_ld: begin
					we = 1'b1;
					wr_data = md_q;
				end
				// link register is the rb field
				op_jal: begin
					we = 1'b1;
					wr_addr = ir.imm.rb;
					wr_data = {{(32-ADDR_W){1'b0}}, pc_inc};
				end
				default:
					we = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_fetch_wait && mem_ack)
			ir <= instr_t'(mem_rdata);
		if (state == s_data_wait && mem_ack)
			md_q <= mem_rdata;
		if (state == s_exec) begin
			res_q <= result;
			taken_q <= taken;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			pc <= ADDR_W'(RESET_PC);
			out_data <= '0;
			out_strobe <= 1'b0;
		end else begin
			out_strobe <= 1'b0;
			case (state)
				s_idle: begin
					if (run) begin
						pc <= ADDR_W'(RESET_PC);
						state <= s_start;
					end
				end
				// let any cut host transaction finish its release
				s_start:
					if (!mem_ack)
						state <= s_fetch_req;
				s_fetch_req:
					state <= s_fetch_wait;
				s_fetch_wait:
					if (mem_ack)
						state <= s_fetch_rel;
				s_fetch_rel:
					if (!mem_ack)
						state <= s_exec;
				s_exec: begin
					if (op == op_halt)
						state <= s_halt;
					else if (op == op_ld || op == op_st)
						state <= s_data_req;
					else
						state <= s_wb;
				end
				s_data_req:
					state <= s_data_wait;
				s_data_wait:
					if (mem_ack)
						state <= s_data_rel;
				s_data_rel:
					if (!mem_ack)
						state <= s_wb;
				s_wb: begin
					if ((op == op_br && taken_q) || op == op_jr || op == op_jal)
						pc <= res_q[ADDR_W-1:0];
					else
						pc <= pc_inc;
					if (op == op_out) begin
						out_data <= res_q;
						out_strobe <= 1'b1;
					end
					// run dropped mid program, stop between instructions
					state <= run ? s_fetch_req : s_idle;
				end
				s_halt:
					if (!run)
						state <= s_idle;
				default:
					state <= s_idle;
			endcase
		end
	end

endmodule

/* src/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
	parameter int ADDR_W   = 9,
	parameter int RESET_PC = 0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,
	input  mem_pkg::word_t       in_data,
	input  logic                 host_req,
	input  mem_pkg::mem_op_t     host_op,
	input  logic [ADDR_W-1:0]    host_addr,
	input  mem_pkg::word_t       host_wdata,
	output logic                 halted,
	output mem_pkg::word_t       out_data,
	output logic                 out_strobe,
	output logic                 host_ack,
	output mem_pkg::word_t       host_rdata
);
	import isa_pkg::*;
	import mem_pkg::*;

	// memory bus
	logic              mem_req;
	mem_op_t           mem_op;
	logic [ADDR_W-1:0] mem_addr;
	word_t             mem_wdata;
	logic              mem_ack;
	word_t             mem_rdata;

	// register file
	logic [3:0]        ra_addr;
	logic [3:0]        rb_addr;
	word_t             ra_data;
	word_t             rb_data;
	logic              we;
	logic [3:0]        wr_addr;
	word_t             wr_data;

	// alu
	alu_op_t           alu_op;
	word_t             alu_a;
	word_t             alu_b;
	br_cond_t          cond;
	word_t             test;
	word_t             result;
	logic              taken;

	control_unit #(
		.ADDR_W   (ADDR_W),
		.RESET_PC (RESET_PC)
	) u_control (.*);

	reg_file u_regs (.*);

	alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.cond   (cond),
		.test   (test),
		.result (result),
		.taken  (taken)
	);

	ram #(
		.ADDR_W (ADDR_W)
	) u_ram (.*);

endmodule

/* tb/cpu_assert.sv */
`timescale 1ns/10ps

module cpu_assert (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic mem_req,
	input logic mem_ack,
	input logic halted
);

	// ack only answers a request seen on the edge before
	a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_ack) |-> $past(mem_req))
		else $error("mem_ack rose without a pending mem_req");

	// an open request stays up until the slave answers
	a_req_holds: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	// ack released only after the master let go
	a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(mem_ack) |-> !$past(mem_req))
		else $error("mem_ack fell while mem_req was still high");

	// halted is sticky while run is held
	a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted && run |=> halted)
		else $error("halted fell while run was still high");

endmodule

bind control_unit cpu_assert u_assert (
	.clk     (clk),
	.rst_n   (rst_n),
	.run     (run),
	.mem_req (mem_req),
	.mem_ack (mem_ack),
	.halted  (halted)
);

/* tb/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;
	import isa_pkg::*;
	import mem_pkg::*;

	localparam int ADDR_W = 9;
	localparam int DEPTH = 2 ** ADDR_W;
	// cycle limits for one handshake phase and for one program
	localparam int HS_LIMIT = 50;
	localparam int RUN_LIMIT = 5000;

	logic              clk = 1'b0;
	logic              rst_n;
	logic              run;
	word_t             in_data;
	logic              host_req;
	mem_op_t           host_op;
	logic [ADDR_W-1:0] host_addr;
	word_t             host_wdata;
	logic              halted;
	word_t             out_data;
	logic              out_strobe;
	logic              host_ack;
	word_t             host_rdata;

	word_t seed;
	// program image waiting to be loaded
	word_t prog [$];
	// observed and expected out port values
	word_t out_q [$];
	word_t exp_q [$];
	word_t model [DEPTH];

	cpu_top #(
		.ADDR_W   (ADDR_W),
		.RESET_PC (0)
	) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.in_data    (in_data),
		.host_req   (host_req),
		.host_op    (host_op),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.halted     (halted),
		.out_data   (out_data),
		.out_strobe (out_strobe),
		.host_ack   (host_ack),
		.host_rdata (host_rdata)
	);

	always #20 clk = ~clk;

	// one entry per strobe pulse sampled mid cycle
	always @(negedge clk) begin
		if (rst_n && out_strobe)
			out_q.push_back(out_data);
	end

	function automatic word_t lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// op, ra, rb, 19-bit constant
	function automatic word_t enc(input opcode_t op, input int ra, input int rb, input int c);
		return {op, ra[3:0], rb[3:0], c[18:0]};
	endfunction

	// condition code sits in the low half of the rb field
	function automatic word_t enc_br(input int ra, input int cnd, input int c);
		return {op_br, ra[3:0], 2'b00, cnd[1:0], c[18:0]};
	endfunction

	// two's complement value of the low 19 bits
	function automatic word_t sext19(input int c);
		word_t v;
		v = word_t'(c[18:0]);
		if (c[18])
			v = v - 32'h0008_0000;
		return v;
	endfunction

	// 0 zero, 1 nonzero, 2 positive, 3 negative
	function automatic int cond_holds(input int cnd, input word_t v);
		case (cnd)
			0: return (v == 0) ? 1 : 0;
			1: return (v != 0) ? 1 : 0;
			2: return ($signed(v) > 0) ? 1 : 0;
			default: return ($signed(v) < 0) ? 1 : 0;
		endcase
	endfunction

	task automatic check_eq(input word_t actual, input word_t expected, input string what);
		if (actual !== expected) begin
			$display("** Error @ %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic wait_host_ack(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (host_ack !== level) begin
			cycles++;
			if (cycles > HS_LIMIT) begin
				$display("TB FAILED");
				$fatal(1, "timeout waiting for host_ack to become %0b", level);
			end
			@(negedge clk);
		end
	endtask

	task automatic wait_halted(input logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (halted !== level) begin
			cycles++;
			if (cycles > RUN_LIMIT) begin
				$display("TB FAILED");
				$fatal(1, "timeout waiting for halted to become %0b", level);
			end
			@(negedge clk);
		end
	endtask

	task automatic host_write(input int addr, input word_t data);
		@(posedge clk);
		host_req <= 1'b1;
		host_op <= mem_write;
		host_addr <= addr[ADDR_W-1:0];
		host_wdata <= data;
		wait_host_ack(1'b1);
		@(posedge clk);
		host_req <= 1'b0;
		wait_host_ack(1'b0);
	endtask

	task automatic host_read(input int addr, output word_t data);
		@(posedge clk);
		host_req <= 1'b1;
		host_op <= mem_read;
		host_addr <= addr[ADDR_W-1:0];
		wait_host_ack(1'b1);
		// rdata valid while ack is high
		data = host_rdata;
		@(posedge clk);
		host_req <= 1'b0;
		wait_host_ack(1'b0);
	endtask

	task automatic load_program(input int org);
		for (int i = 0; i < prog.size(); i++)
			host_write(org + i, prog[i]);
		prog.delete();
	endtask

	// start at word 0, wait for halt, then release run
	task automatic run_program();
		out_q.delete();
		@(posedge clk);
		run <= 1'b1;
		wait_halted(1'b1);
		@(posedge clk);
		run <= 1'b0;
		wait_halted(1'b0);
	endtask

	task automatic check_outs(input string what);
		check_eq(out_q.size(), exp_q.size(), {what, " out count"});
		for (int i = 0; i < exp_q.size(); i++)
			check_eq(out_q[i], exp_q[i], {what, " out value"});
		exp_q.delete();
	endtask

	task automatic test_host_memory();
		int addrs [32];
		word_t r;
		word_t rd;
		for (int i = 0; i < 32; i++) begin
			r = lcg_next();
			addrs[i] = int'(r[31:23]);
			model[addrs[i]] = lcg_next();
			host_write(addrs[i], model[addrs[i]]);
		end
		// repeated addresses read back their last write
		for (int i = 0; i < 32; i++) begin
			host_read(addrs[i], rd);
			check_eq(rd, model[addrs[i]], "host readback");
		end
	endtask

	task automatic test_immediate_ops();
		int c1, c3, c4;
		word_t e1;
		word_t e2;
		word_t e3;
		c1 = int'(lcg_next() >> 13);
		c3 = int'(lcg_next() >> 13);
		c4 = int'(lcg_next() >> 13);
		prog.push_back(enc(op_ldi, 1, 0, c1));
		prog.push_back(enc(op_out, 1, 0, 0));
		prog.push_back(enc(op_addi, 2, 1, -100));
		prog.push_back(enc(op_out, 2, 0, 0));
		prog.push_back(enc(op_andi, 3, 2, c3));
		prog.push_back(enc(op_out, 3, 0, 0));
		prog.push_back(enc(op_ori, 4, 3, c4));
		prog.push_back(enc(op_out, 4, 0, 0));
		// ldi with a base register adds it to the constant
		prog.push_back(enc(op_ldi, 5, 1, 7));
		prog.push_back(enc(op_out, 5, 0, 0));
		prog.push_back(enc(op_halt, 0, 0, 0));
		e1 = sext19(c1);
		e2 = e1 + sext19(-100);
		e3 = e2 & sext19(c3);
		exp_q.push_back(e1);
		exp_q.push_back(e2);
		exp_q.push_back(e3);
		exp_q.push_back(e3 | sext19(c4));
		exp_q.push_back(e1 + 7);
		load_program(0);
		run_program();
		check_outs("immediate ops");
	endtask

	task automatic test_load_store();
		int dv;
		word_t pre;
		word_t rd;
		dv = int'(lcg_next() >> 13);
		pre = lcg_next();
		host_write('h130, pre);
		// r0 is nonzero yet an rb field of 0 still means base 0
		prog.push_back(enc(op_ldi, 0, 0, 'h55));
		prog.push_back(enc(op_ldi, 1, 0, 'h100));
		prog.push_back(enc(op_ldi, 2, 0, dv));
		prog.push_back(enc(op_st, 2, 0, 'h120));
		prog.push_back(enc(op_st, 2, 1, 5));
		prog.push_back(enc(op_addi, 3, 2, 1));
		// negative offset from the base
		prog.push_back(enc(op_st, 3, 1, -1));
		prog.push_back(enc(op_ld, 4, 0, 'h120));
		prog.push_back(enc(op_out, 4, 0, 0));
		prog.push_back(enc(op_ld, 5, 1, 5));
		prog.push_back(enc(op_out, 5, 0, 0));
		// host preloaded word moved to a new slot
		prog.push_back(enc(op_ld, 7, 1, 'h30));
		prog.push_back(enc(op_st, 7, 0, 'h131));
		prog.push_back(enc(op_out, 7, 0, 0));
		prog.push_back(enc(op_halt, 0, 0, 0));
		exp_q.push_back(sext19(dv));
		exp_q.push_back(sext19(dv));
		exp_q.push_back(pre);
		load_program(0);
		run_program();
		check_outs("load store");
		host_read('h120, rd);
		check_eq(rd, sext19(dv), "st zero base");
		host_read('h105, rd);
		check_eq(rd, sext19(dv), "st with base");
		host_read('h0ff, rd);
		check_eq(rd, sext19(dv) + 1, "st negative offset");
		host_read('h131, rd);
		check_eq(rd, pre, "ld then st");
	endtask

	task automatic test_branches();
		int vals [4];
		int k;
		vals[1] = 0;
		vals[2] = int'(lcg_next() & 32'h3ffff) | 1;
		// bit 18 set so the value is negative after sign extension
		vals[3] = int'(lcg_next() & 32'h3ffff) | 'h40000;
		for (int r = 1; r < 4; r++)
			prog.push_back(enc(op_ldi, r, 0, vals[r]));
		// r9 preset to the taken value and overwritten on fall through
		for (int cnd = 0; cnd < 4; cnd++) begin
			for (int r = 1; r < 4; r++) begin
				k = cnd * 3 + r - 1;
				prog.push_back(enc(op_ldi, 9, 0, 101 + 2 * k));
				prog.push_back(enc_br(r, cnd, 1));
				prog.push_back(enc(op_ldi, 9, 0, 100 + 2 * k));
				prog.push_back(enc(op_out, 9, 0, 0));
				exp_q.push_back(100 + 2 * k + cond_holds(cnd, sext19(vals[r])));
			end
		end
		// countdown loop with a backward brnz to the addi
		prog.push_back(enc(op_ldi, 5, 0, 3));
		prog.push_back(enc(op_addi, 5, 5, -1));
		prog.push_back(enc(op_out, 5, 0, 0));
		prog.push_back(enc_br(5, 1, -3));
		prog.push_back(enc(op_halt, 0, 0, 0));
		for (int n = 2; n >= 0; n--)
			exp_q.push_back(n);
		load_program(0);
		run_program();
		check_outs("branches");
	endtask

	task automatic test_jumps_input();
		word_t in_val;
		word_t rd;
		in_val = lcg_next();
		@(posedge clk);
		in_data <= in_val;
		prog.push_back(enc(op_ldi, 1, 0, 'h40));
		// jal at word 1 links into r14
		prog.push_back(enc(op_jal, 1, 14, 0));
		prog.push_back(enc(op_st, 14, 0, 'h150));
		prog.push_back(enc(op_ldi, 9, 0, 'h77));
		prog.push_back(enc(op_out, 9, 0, 0));
		prog.push_back(enc(op_halt, 0, 0, 0));
		load_program(0);
		// routine at 0x40
		prog.push_back(enc(op_in, 2, 0, 0));
		prog.push_back(enc(op_out, 2, 0, 0));
		prog.push_back(enc(op_jr, 14, 0, 0));
		load_program('h40);
		exp_q.push_back(in_val);
		exp_q.push_back('h77);
		run_program();
		check_outs("jumps");
		host_read('h150, rd);
		check_eq(rd, 1 + 1, "jal link value");
	endtask

	initial begin
		seed = 32'h6e400b81;
		rst_n = 1'b0;
		run = 1'b0;
		in_data = '0;
		host_req = 1'b0;
		host_op = mem_read;
		host_addr = '0;
		host_wdata = '0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_eq(32'({halted, out_strobe, host_ack}), 0, "status after reset");
		check_eq(out_data, 0, "out_data after reset");
		test_host_memory();
		test_immediate_ops();
		test_load_store();
		test_branches();
		test_jumps_input();
		$display("TB PASSED");
		$finish;
	end

endmodule

/* build.f */
src/isa_pkg.sv
src/mem_pkg.sv
src/ram.sv
src/reg_file.sv
src/alu.sv
src/control_unit.sv
src/cpu_top.sv
tb/cpu_assert.sv
tb/cpu_tb.sv

/* Makefile */
TOP = cpu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f build.f -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
